//--- Bender.yml
package:
  name: amber_axi_subsys

sources:
  - include_dirs:
      - hw
    files:
      - hw/axi_types_pkg.sv
      - hw/mem_req_pkg.sv
      - hw/axi4_if.sv
      - hw/amber_axi_master.sv
      - hw/axi_bank_router.sv
      - hw/axi_mem_bank.sv
      - hw/axi_resp_merge.sv
      - hw/amber_axi_subsys.sv
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/amber_axi_checker.sv
      - testbench/tb_amber_axi_subsys.sv

//--- amber_axi_subsys.f
+incdir+hw
hw/axi_types_pkg.sv
hw/mem_req_pkg.sv
hw/axi4_if.sv
hw/amber_axi_master.sv
hw/axi_bank_router.sv
hw/axi_mem_bank.sv
hw/axi_resp_merge.sv
hw/amber_axi_subsys.sv
testbench/amber_axi_checker.sv
testbench/tb_amber_axi_subsys.sv

//--- hw/amber_axi_cfg.svh
`ifndef AMBER_AXI_CFG_SVH
`define AMBER_AXI_CFG_SVH

// ============================================================
// memory subsystem sizing
// ============================================================

// width of one data word in bits
`define AMBER_DATA_W 32

// byte address width seen by the core
`define AMBER_ADDR_W 32

// number of banks, must stay a power of two
`define AMBER_NBANKS 4

// words held by each bank
`define AMBER_BANK_WORDS 64

// cache line length in words
`define AMBER_LINE_WORDS 4

`endif

//--- hw/amber_axi_master.sv
`include "amber_axi_cfg.svh"

module amber_axi_master (
	input  logic                     i_clk,
	input  logic                     i_rst_n,
	// core side, held until the stall falls
	input  logic                     i_select,
	input  logic                     i_write_enable,
	input  axi_types_pkg::axi_strb_t i_byte_enable,
	input  axi_types_pkg::axi_addr_t i_address,
	input  axi_types_pkg::axi_data_t i_write_data,
	input  logic                     i_cache_req,
	output logic                     o_stall,
	output logic                     o_stall_cache,
	output axi_types_pkg::axi_data_t o_read_data,
	output logic                     o_read_valid,
	output axi_types_pkg::axi_data_t o_cache_data,
	output logic                     o_cache_valid,
	axi4_if.master                   m
);
	import axi_types_pkg::*;
	import mem_req_pkg::*;

	rd_state_e rd_state;
	wr_state_e wr_state;
	logic      core_rd_req;
	logic      core_wr_req;
	logic      cache_rd_req;
	logic      cache_wr_req;
	logic      ar_hs;
	logic      r_hs;
	logic      aw_hs;
	logic      w_hs;
	logic      b_hs;
	axi_data_t core_rd_q;
	axi_data_t cache_rd_q;

	// request decode, write enable is shared by core and cache
	assign core_rd_req  = i_select && !i_write_enable;
	assign core_wr_req  = i_select && i_write_enable;
	assign cache_rd_req = i_cache_req && !i_write_enable;
	assign cache_wr_req = i_cache_req && i_write_enable;

	assign ar_hs = m.arvalid && m.arready;
	assign r_hs  = m.rvalid && m.rready;
	assign aw_hs = m.awvalid && m.awready;
	assign w_hs  = m.wvalid && m.wready;
	assign b_hs  = m.bvalid && m.bready;

	// ============================================================
	// read FSM
	// ============================================================
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			rd_state <= RD_IDLE;
		end else begin
			case (rd_state)
				RD_IDLE: begin
					// cache line fills win over core reads
					if (cache_rd_req) begin
						rd_state <= RD_CACHE_ADDR;
					end else if (core_rd_req) begin
						rd_state <= RD_CORE_ADDR;
					end
				end
				RD_CORE_ADDR: begin
					if (ar_hs) begin
						rd_state <= RD_CORE_DATA;
					end
				end
				RD_CACHE_ADDR: begin
					if (ar_hs) begin
						rd_state <= RD_CACHE_DATA;
					end
				end
				default: begin
					// both data states finish on the last beat
					if (r_hs && m.rlast) begin
						rd_state <= RD_IDLE;
					end
				end
			endcase
		end
	end

	// ============================================================
	// write FSM
	// ============================================================
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			wr_state <= WR_IDLE;
		end else begin
			case (wr_state)
				WR_IDLE: begin
					if (cache_wr_req || core_wr_req) begin
						wr_state <= WR_ADDR;
					end
				end
				WR_ADDR: begin
					if (aw_hs) begin
						wr_state <= WR_DATA;
					end
				end
				WR_DATA: begin
					if (w_hs) begin
						wr_state <= WR_RESP;
					end
				end
				default: begin
					if (b_hs) begin
						wr_state <= WR_IDLE;
					end
				end
			endcase
		end
	end

	// read address, a line fill wraps around the requested word
	assign m.arvalid = (rd_state == RD_CORE_ADDR) || (rd_state == RD_CACHE_ADDR);
	assign m.araddr  = i_address;
	assign m.arlen   = (rd_state == RD_CACHE_ADDR) ? axi_len_t'(`AMBER_LINE_WORDS - 1) : '0;
	assign m.arsize  = AXI_SIZE_WORD;
	assign m.arburst = (rd_state == RD_CACHE_ADDR) ? AXI_BURST_WRAP : AXI_BURST_INCR;
	// never back-pressure the banks
	assign m.rready  = (rd_state == RD_CORE_DATA) || (rd_state == RD_CACHE_DATA);

	// single beat writes
	assign m.awvalid = (wr_state == WR_ADDR);
	assign m.awaddr  = i_address;
	assign m.awlen   = '0;
	assign m.awsize  = AXI_SIZE_WORD;
	assign m.awburst = AXI_BURST_INCR;
	assign m.wvalid  = (wr_state == WR_DATA);
	assign m.wdata   = i_write_data;
	// write-backs replace the whole word
	assign m.wstrb   = i_cache_req ? {$bits(axi_strb_t){1'b1}} : i_byte_enable;
	assign m.wlast   = (wr_state == WR_DATA);
	assign m.bready  = (wr_state == WR_RESP);

	// data pulses line up with the accepted beat
	assign o_read_valid  = (rd_state == RD_CORE_DATA) && r_hs;
	assign o_cache_valid = (rd_state == RD_CACHE_DATA) && r_hs;

	// keep the last returned word after the pulse
	always_ff @(posedge i_clk) begin
		if (o_read_valid) begin
			core_rd_q <= m.rdata;
		end
		if (o_cache_valid) begin
			cache_rd_q <= m.rdata;
		end
	end

	assign o_read_data  = o_read_valid ? m.rdata : core_rd_q;
	assign o_cache_data = o_cache_valid ? m.rdata : cache_rd_q;

	// stalls drop in the cycle the transaction completes
	assign o_stall = (core_rd_req && !o_read_valid) ||
		((core_wr_req || cache_wr_req) && !((wr_state == WR_RESP) && b_hs));
	assign o_stall_cache = cache_rd_req && !(o_cache_valid && m.rlast);

endmodule

//--- hw/amber_axi_subsys.sv
`include "amber_axi_cfg.svh"

module amber_axi_subsys (
	input  logic                     i_clk,
	input  logic                     i_rst_n,
	// core and cache requests
	input  logic                     i_select,
	input  logic                     i_write_enable,
	input  axi_types_pkg::axi_strb_t i_byte_enable,
	input  axi_types_pkg::axi_addr_t i_address,
	input  axi_types_pkg::axi_data_t i_write_data,
	input  logic                     i_cache_req,
	// stalls and returned data
	output logic                     o_stall,
	output logic                     o_stall_cache,
	output axi_types_pkg::axi_data_t o_read_data,
	output logic                     o_read_valid,
	output axi_types_pkg::axi_data_t o_cache_data,
	output logic                     o_cache_valid
);

	// master side link and one link per bank
	axi4_if m_link ();
	axi4_if bank_link [`AMBER_NBANKS] ();

	amber_axi_master master_i (
		.i_clk          (i_clk),
		.i_rst_n        (i_rst_n),
		.i_select       (i_select),
		.i_write_enable (i_write_enable),
		.i_byte_enable  (i_byte_enable),
		.i_address      (i_address),
		.i_write_data   (i_write_data),
		.i_cache_req    (i_cache_req),
		.o_stall        (o_stall),
		.o_stall_cache  (o_stall_cache),
		.o_read_data    (o_read_data),
		.o_read_valid   (o_read_valid),
		.o_cache_data   (o_cache_data),
		.o_cache_valid  (o_cache_valid),
		.m              (m_link)
	);

	// request channels out to the banks
	axi_bank_router router_i (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.s       (m_link),
		.m       (bank_link)
	);

	for (genvar g = 0; g < `AMBER_NBANKS; g++) begin : g_bank
		axi_mem_bank bank_i (
			.i_clk   (i_clk),
			.i_rst_n (i_rst_n),
			.s       (bank_link[g])
		);
	end

	// R and B back onto the master link
	axi_resp_merge merge_i (
		.s (bank_link),
		.m (m_link)
	);

endmodule

//--- hw/axi4_if.sv
interface axi4_if;
	import axi_types_pkg::*;

	// write address channel
	logic       awvalid;
	logic       awready;
	axi_addr_t  awaddr;
	axi_len_t   awlen;
	axi_size_t  awsize;
	axi_burst_e awburst;
	// write data channel
	logic       wvalid;
	logic       wready;
	axi_data_t  wdata;
	axi_strb_t  wstrb;
	logic       wlast;
	// write response channel
	logic       bvalid;
	logic       bready;
	axi_resp_t  bresp;
	// read address channel
	logic       arvalid;
	logic       arready;
	axi_addr_t  araddr;
	axi_len_t   arlen;
	axi_size_t  arsize;
	axi_burst_e arburst;
	// read data channel
	logic       rvalid;
	logic       rready;
	axi_data_t  rdata;
	axi_resp_t  rresp;
	logic       rlast;

	modport master (
		output awvalid, awaddr, awlen, awsize, awburst, input awready,
		output wvalid, wdata, wstrb, wlast, input wready,
		input bvalid, bresp, output bready,
		output arvalid, araddr, arlen, arsize, arburst, input arready,
		input rvalid, rdata, rresp, rlast, output rready
	);

	modport slave (
		input awvalid, awaddr, awlen, awsize, awburst, output awready,
		input wvalid, wdata, wstrb, wlast, output wready,
		output bvalid, bresp, input bready,
		input arvalid, araddr, arlen, arsize, arburst, output arready,
		output rvalid, rdata, rresp, rlast, input rready
	);

endinterface

//--- hw/axi_bank_router.sv
`include "amber_axi_cfg.svh"

module axi_bank_router (
	input  logic   i_clk,
	input  logic   i_rst_n,
	axi4_if.slave  s,
	axi4_if.master m [`AMBER_NBANKS]
);
	import mem_req_pkg::*;

	localparam int NB = `AMBER_NBANKS;

	bank_idx_t     ar_bank;
	bank_idx_t     aw_bank;
	bank_idx_t     wr_bank;
	logic          wr_open;
	logic [NB-1:0] arready_v;
	logic [NB-1:0] awready_v;
	logic [NB-1:0] wready_v;

	// bank select bits from the request addresses
	assign ar_bank = s.araddr[BANK_LSB +: $bits(bank_idx_t)];
	assign aw_bank = s.awaddr[BANK_LSB +: $bits(bank_idx_t)];

	// remember where the write went so W follows its AW
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			wr_open <= 1'b0;
			wr_bank <= '0;
		end else if (s.awvalid && s.awready) begin
			wr_open <= 1'b1;
			wr_bank <= aw_bank;
		end else if (s.bvalid && s.bready) begin
			// response seen so the write is closed
			wr_open <= 1'b0;
		end
	end

	// ============================================================
	// per bank request steering
	// ============================================================
	for (genvar i = 0; i < NB; i++) begin : g_bank
		// only valid is steered, payload fans out to every bank
		assign m[i].arvalid = s.arvalid && (ar_bank == bank_idx_t'(i));
		assign m[i].araddr  = s.araddr;
		assign m[i].arlen   = s.arlen;
		assign m[i].arsize  = s.arsize;
		assign m[i].arburst = s.arburst;
		// no new AW while a write is still open
		assign m[i].awvalid = s.awvalid && !wr_open && (aw_bank == bank_idx_t'(i));
		assign m[i].awaddr  = s.awaddr;
		assign m[i].awlen   = s.awlen;
		assign m[i].awsize  = s.awsize;
		assign m[i].awburst = s.awburst;
		assign m[i].wvalid  = s.wvalid && wr_open && (wr_bank == bank_idx_t'(i));
		assign m[i].wdata   = s.wdata;
		assign m[i].wstrb   = s.wstrb;
		assign m[i].wlast   = s.wlast;
		assign arready_v[i] = m[i].arready;
		assign awready_v[i] = m[i].awready;
		assign wready_v[i]  = m[i].wready;
	end

	// ready comes back from the selected bank only
	assign s.arready = arready_v[ar_bank];
	assign s.awready = !wr_open && awready_v[aw_bank];
	assign s.wready  = wr_open && wready_v[wr_bank];

endmodule

//--- hw/axi_mem_bank.sv
`include "amber_axi_cfg.svh"

module axi_mem_bank (
	input  logic  i_clk,
	input  logic  i_rst_n,
	axi4_if.slave s
);
	import axi_types_pkg::*;
	import mem_req_pkg::*;

	localparam int OFF_W  = $clog2(`AMBER_LINE_WORDS);
	localparam int WORD_W = $clog2(`AMBER_BANK_WORDS);

	typedef logic [WORD_W-1:0] word_idx_t;

	axi_data_t  mem [`AMBER_BANK_WORDS];
	logic       arready_q;
	logic       rvalid_q;
	logic       rd_last;
	beat_cnt_t  rd_cnt;
	axi_len_t   rd_len;
	axi_burst_e rd_burst;
	word_idx_t  rd_word;
	logic       wready_q;
	logic       bvalid_q;
	logic       aw_free;
	word_idx_t  wr_word;
	logic       ar_hs;
	logic       r_hs;
	logic       aw_hs;
	logic       w_hs;
	logic       b_hs;

	// row bits on top, line offset kept in the low bits
	function automatic word_idx_t word_of(input axi_addr_t addr);
		return {addr[ROW_LSB +: WORD_W - OFF_W], addr[LINE_LSB +: OFF_W]};
	endfunction

	assign aw_free = !wready_q && !bvalid_q;
	assign ar_hs   = s.arvalid && arready_q;
	assign r_hs    = rvalid_q && s.rready;
	assign aw_hs   = s.awvalid && aw_free;
	assign w_hs    = s.wvalid && wready_q;
	assign b_hs    = bvalid_q && s.bready;
	assign rd_last = (axi_len_t'(rd_cnt) == rd_len);

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			arready_q <= 1'b0;
			rvalid_q  <= 1'b0;
			rd_cnt    <= '0;
			wready_q  <= 1'b0;
			bvalid_q  <= 1'b0;
		end else begin
			// accept AR one cycle after it shows up, only between bursts
			arready_q <= s.arvalid && !arready_q && !rvalid_q;
			if (ar_hs) begin
				rvalid_q <= 1'b1;
				rd_cnt   <= '0;
			end else if (r_hs) begin
				rvalid_q <= !rd_last;
				rd_cnt   <= rd_cnt + 1'b1;
			end
			// AW then W then B, one cycle each at the earliest
			wready_q <= aw_hs || (wready_q && !w_hs);
			bvalid_q <= w_hs || (bvalid_q && !b_hs);
		end
	end

	// word array, byte lanes written under strobe
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			for (int i = 0; i < `AMBER_BANK_WORDS; i++) begin
				mem[i] <= '0;
			end
		end else if (w_hs) begin
			for (int b = 0; b < $bits(axi_strb_t); b++) begin
				if (s.wstrb[b]) begin
					mem[wr_word][8*b +: 8] <= s.wdata[8*b +: 8];
				end
			end
		end
	end

	// burst address tracking
	always_ff @(posedge i_clk) begin
		if (aw_hs) begin
			wr_word <= word_of(s.awaddr);
		end
		if (ar_hs) begin
			rd_word  <= word_of(s.araddr);
			rd_len   <= s.arlen;
			rd_burst <= s.arburst;
		end else if (r_hs) begin
			case (rd_burst)
				// stay inside the line
				AXI_BURST_WRAP: rd_word[OFF_W-1:0] <= rd_word[OFF_W-1:0] + 1'b1;
				AXI_BURST_INCR: rd_word <= rd_word + 1'b1;
				// fixed bursts reread the same word
				default: ;
			endcase
		end
	end

	assign s.arready = arready_q;
	assign s.rvalid  = rvalid_q;
	assign s.rdata   = mem[rd_word];
	assign s.rresp   = AXI_RESP_OKAY;
	assign s.rlast   = rd_last;
	assign s.awready = aw_free;
	assign s.wready  = wready_q;
	assign s.bvalid  = bvalid_q;
	assign s.bresp   = AXI_RESP_OKAY;

endmodule

//--- hw/axi_resp_merge.sv
`include "amber_axi_cfg.svh"

module axi_resp_merge (
	axi4_if.master s [`AMBER_NBANKS],
	axi4_if.slave  m
);
	import axi_types_pkg::*;

	localparam int NB = `AMBER_NBANKS;

	logic [NB-1:0] rvalid_v;
	logic [NB-1:0] rlast_v;
	logic [NB-1:0] bvalid_v;
	axi_data_t     rdata_v [NB];
	axi_resp_t     rresp_v [NB];
	axi_resp_t     bresp_v [NB];
	axi_data_t     rdata_or;
	axi_resp_t     rresp_or;
	axi_resp_t     bresp_or;

	// ============================================================
	// gather per bank responses, masked by their valid
	// ============================================================
	for (genvar i = 0; i < NB; i++) begin : g_bank
		assign rvalid_v[i] = s[i].rvalid;
		assign rlast_v[i]  = s[i].rvalid && s[i].rlast;
		assign rdata_v[i]  = s[i].rvalid ? s[i].rdata : '0;
		assign rresp_v[i]  = s[i].rvalid ? s[i].rresp : '0;
		assign bvalid_v[i] = s[i].bvalid;
		assign bresp_v[i]  = s[i].bvalid ? s[i].bresp : '0;
		// ready fans back to every bank
		assign s[i].rready = m.rready;
		assign s[i].bready = m.bready;
	end

	// at most one bank is active per channel so OR picks it
	always_comb begin
		rdata_or = '0;
		rresp_or = '0;
		bresp_or = '0;
		for (int i = 0; i < NB; i++) begin
			rdata_or |= rdata_v[i];
			rresp_or |= rresp_v[i];
			bresp_or |= bresp_v[i];
		end
	end

	assign m.rvalid = |rvalid_v;
	assign m.rdata  = rdata_or;
	assign m.rresp  = rresp_or;
	assign m.rlast  = |rlast_v;
	assign m.bvalid = |bvalid_v;
	assign m.bresp  = bresp_or;

endmodule

//--- hw/axi_types_pkg.sv
`include "amber_axi_cfg.svh"

package axi_types_pkg;

	// ============================================================
	// AXI4 field types for the subset in use
	// ============================================================

	typedef logic [`AMBER_ADDR_W-1:0] axi_addr_t;
	typedef logic [`AMBER_DATA_W-1:0] axi_data_t;
	// one strobe per data byte
	typedef logic [`AMBER_DATA_W/8-1:0] axi_strb_t;
	// number of beats minus one
	typedef logic [7:0] axi_len_t;
	typedef logic [2:0] axi_size_t;
	typedef logic [1:0] axi_resp_t;

	// burst encodings as on the wire
	typedef enum logic [1:0] {
		AXI_BURST_FIXED = 2'b00,
		AXI_BURST_INCR  = 2'b01,
		AXI_BURST_WRAP  = 2'b10
	} axi_burst_e;

	// full width beats only
	localparam axi_size_t AXI_SIZE_WORD = axi_size_t'($clog2(`AMBER_DATA_W / 8));

	// normal access response
	localparam axi_resp_t AXI_RESP_OKAY = 2'b00;

endpackage

//--- hw/mem_req_pkg.sv
`include "amber_axi_cfg.svh"

package mem_req_pkg;

	// line offset starts right above the byte lanes
	localparam int LINE_LSB = $clog2(`AMBER_DATA_W / 8);
	// bank index sits above the line offset
	localparam int BANK_LSB = LINE_LSB + $clog2(`AMBER_LINE_WORDS);
	// row of lines inside a bank
	localparam int ROW_LSB  = BANK_LSB + $clog2(`AMBER_NBANKS);

	typedef logic [$clog2(`AMBER_NBANKS)-1:0]     bank_idx_t;
	typedef logic [$clog2(`AMBER_LINE_WORDS)-1:0] beat_cnt_t;

	// master read FSM
	typedef enum logic [2:0] {
		RD_IDLE, RD_CORE_ADDR, RD_CORE_DATA, RD_CACHE_ADDR, RD_CACHE_DATA
	} rd_state_e;

	// master write FSM
	typedef enum logic [1:0] {
		WR_IDLE, WR_ADDR, WR_DATA, WR_RESP
	} wr_state_e;

endpackage

//--- testbench/amber_axi_checker.sv
`include "amber_axi_cfg.svh"

module amber_axi_checker (
	input  logic                     i_clk,
	input  logic                     i_rst_n,
	// requests as the DUT sees them
	input  logic                     i_select,
	input  logic                     i_write_enable,
	input  axi_types_pkg::axi_strb_t i_byte_enable,
	input  axi_types_pkg::axi_addr_t i_address,
	input  axi_types_pkg::axi_data_t i_write_data,
	input  logic                     i_cache_req,
	// DUT responses
	input  logic                     i_stall,
	input  logic                     i_stall_cache,
	input  axi_types_pkg::axi_data_t i_read_data,
	input  logic                     i_read_valid,
	input  axi_types_pkg::axi_data_t i_cache_data,
	input  logic                     i_cache_valid,
	// running totals for the summary
	output int                       o_checks,
	output int                       o_errors
);
	import axi_types_pkg::*;

	localparam int MEM_WORDS  = `AMBER_NBANKS * `AMBER_BANK_WORDS;
	localparam int LINE_WORDS = `AMBER_LINE_WORDS;

	// reference memory, one entry per word over all banks
	axi_data_t model [MEM_WORDS];
	int        read_pulses;
	int        cache_beats;

	// flat word number from a byte address
	function automatic int word_index(input axi_addr_t addr);
		return int'(addr >> 2) % MEM_WORDS;
	endfunction

	// beat n of a line fill, wrapping inside the aligned line
	function automatic int wrap_index(input axi_addr_t addr, input int beat);
		int idx;
		int base;
		idx  = word_index(addr);
		base = idx - (idx % LINE_WORDS);
		return base + ((idx + beat) % LINE_WORDS);
	endfunction

	// byte lanes with a set strobe take the new data
	function automatic axi_data_t apply_strobes(input axi_data_t old_word,
		input axi_data_t new_word, input axi_strb_t strb);
		axi_data_t result;
		result = old_word;
		for (int b = 0; b < $bits(axi_strb_t); b++) begin
			if (strb[b]) begin
				result[8*b +: 8] = new_word[8*b +: 8];
			end
		end
		return result;
	endfunction

	task automatic check_word(input string what, input axi_addr_t addr,
		input axi_data_t got, input axi_data_t exp);
		o_checks++;
		if (got !== exp) begin
			o_errors++;
			$display("Fail at %0t: %s at %h returned %h, expected %h", $time, what, addr, got, exp);
		end
	endtask

	task automatic report_problem(input string msg);
		o_errors++;
		$display("Error at %0t: %s", $time, msg);
	endtask

	// ============================================================
	// sampled mid cycle, when inputs and outputs have settled
	// ============================================================
	always @(negedge i_clk) begin : watch
		int idx;
		if (!i_rst_n) begin
			for (int w = 0; w < MEM_WORDS; w++) begin
				model[w] = '0;
			end
			read_pulses = 0;
			cache_beats = 0;
			o_checks    = 0;
			o_errors    = 0;
		end else begin
			// data valids are known once out of reset
			if ($isunknown({i_read_valid, i_cache_valid})) begin
				report_problem("read or cache valid output is unknown after reset");
			end
			// core read data
			if (i_read_valid) begin
				if (!(i_select && !i_write_enable)) begin
					report_problem("read data pulse seen with no core read pending");
				end else begin
					read_pulses++;
					check_word("core read", i_address, i_read_data, model[word_index(i_address)]);
				end
			end
			// a core read ends when its stall drops
			if (i_select && !i_write_enable && !i_stall) begin
				o_checks++;
				if (read_pulses != 1) begin
					report_problem($sformatf("core read at %h gave %0d data pulses instead of one",
						i_address, read_pulses));
				end
				read_pulses = 0;
			end
			// line fill beats
			if (i_cache_valid) begin
				if (!(i_cache_req && !i_write_enable)) begin
					report_problem("cache data pulse seen with no line fill pending");
				end else begin
					idx = wrap_index(i_address, cache_beats);
					check_word("line fill", axi_addr_t'(idx * 4), i_cache_data, model[idx]);
					cache_beats++;
					if (cache_beats == LINE_WORDS && i_stall_cache) begin
						report_problem("cache stall still high on the last line beat");
					end
				end
			end
			if (i_cache_req && !i_write_enable && !i_stall_cache) begin
				o_checks++;
				if (cache_beats != LINE_WORDS) begin
					report_problem($sformatf("line fill at %h gave %0d beats instead of %0d",
						i_address, cache_beats, LINE_WORDS));
				end
				cache_beats = 0;
			end
			// writes land in the model when the response is taken
			if ((i_select || i_cache_req) && i_write_enable && !i_stall) begin
				idx = word_index(i_address);
				if (i_cache_req) begin
					model[idx] = i_write_data;
				end else begin
					model[idx] = apply_strobes(model[idx], i_write_data, i_byte_enable);
				end
			end
		end
	end

endmodule

//--- testbench/tb_amber_axi_subsys.sv
`include "amber_axi_cfg.svh"

module tb_amber_axi_subsys;
	import axi_types_pkg::*;

	localparam int CLK_PERIOD   = 20;
	localparam int DRIVE_DELAY  = 2;
	localparam int RESET_CYCLES = 3;
	localparam int MEM_WORDS    = `AMBER_NBANKS * `AMBER_BANK_WORDS;
	localparam int LINE_WORDS   = `AMBER_LINE_WORDS;
	// test lengths
	localparam int ZERO_READS   = 8;
	localparam int STRB_PAIRS   = 20;
	localparam int FILL_LINES   = 8;
	localparam int WB_PAIRS     = 16;
	localparam int MIX_OPS      = 300;
	localparam int TOTAL_REQS   = ZERO_READS + 2 * STRB_PAIRS + FILL_LINES * (LINE_WORDS + 1)
		+ 2 * WB_PAIRS + MIX_OPS + MEM_WORDS;
	// watchdog budget per request plus slack for reset and idle gaps
	localparam int TIMEOUT_CYCLES = TOTAL_REQS * 200 + 100;

	logic        clk;
	logic        rst_n;
	logic        select;
	logic        write_enable;
	axi_strb_t   byte_enable;
	axi_addr_t   address;
	axi_data_t   write_data;
	logic        cache_req;
	logic        stall;
	logic        stall_cache;
	axi_data_t   read_data;
	logic        read_valid;
	axi_data_t   cache_data;
	logic        cache_valid;
	int          checks;
	int          errors;
	int          errors_before;
	int          tests_run;
	logic [31:0] rng;

	amber_axi_subsys amber_axi_subsys_i (
		.i_clk          (clk),
		.i_rst_n        (rst_n),
		.i_select       (select),
		.i_write_enable (write_enable),
		.i_byte_enable  (byte_enable),
		.i_address      (address),
		.i_write_data   (write_data),
		.i_cache_req    (cache_req),
		.o_stall        (stall),
		.o_stall_cache  (stall_cache),
		.o_read_data    (read_data),
		.o_read_valid   (read_valid),
		.o_cache_data   (cache_data),
		.o_cache_valid  (cache_valid)
	);

	amber_axi_checker axi_checker_i (
		.i_clk          (clk),
		.i_rst_n        (rst_n),
		.i_select       (select),
		.i_write_enable (write_enable),
		.i_byte_enable  (byte_enable),
		.i_address      (address),
		.i_write_data   (write_data),
		.i_cache_req    (cache_req),
		.i_stall        (stall),
		.i_stall_cache  (stall_cache),
		.i_read_data    (read_data),
		.i_read_valid   (read_valid),
		.i_cache_data   (cache_data),
		.i_cache_valid  (cache_valid),
		.o_checks       (checks),
		.o_errors       (errors)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// word aligned and inside the banks
	task automatic random_addr(output axi_addr_t addr);
		rng  = xorshift32(rng);
		addr = axi_addr_t'((rng % MEM_WORDS) * 4);
	endtask

	task automatic random_word(output axi_data_t data);
		rng  = xorshift32(rng);
		data = rng;
	endtask

	// hold the request until its stall is seen low, then step to the next drive point
	task automatic await_release(input logic on_cache);
		@(negedge clk);
		while (on_cache ? stall_cache : stall) begin
			@(negedge clk);
		end
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	task automatic go_idle(input int cycles);
		select       = 1'b0;
		cache_req    = 1'b0;
		write_enable = 1'b0;
		repeat (cycles) @(posedge clk);
		#DRIVE_DELAY;
	endtask

	task automatic core_read(input axi_addr_t addr);
		select       = 1'b1;
		cache_req    = 1'b0;
		write_enable = 1'b0;
		address      = addr;
		await_release(1'b0);
	endtask

	task automatic core_write(input axi_addr_t addr, input axi_data_t data, input axi_strb_t strb);
		select       = 1'b1;
		cache_req    = 1'b0;
		write_enable = 1'b1;
		address      = addr;
		write_data   = data;
		byte_enable  = strb;
		await_release(1'b0);
	endtask

	task automatic line_fill(input axi_addr_t addr);
		select       = 1'b0;
		cache_req    = 1'b1;
		write_enable = 1'b0;
		address      = addr;
		await_release(1'b1);
	endtask

	// a write-back finishes on the core stall
	task automatic write_back(input axi_addr_t addr, input axi_data_t data);
		select       = 1'b0;
		cache_req    = 1'b1;
		write_enable = 1'b1;
		address      = addr;
		write_data   = data;
		// core strobes off, every byte still has to come from the write-back
		byte_enable  = '0;
		await_release(1'b0);
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		$display("%0t: test %s done, %0d errors", $time, name, errors - errors_before);
		errors_before = errors;
	endtask

	// ============================================================
	// stimulus
	// ============================================================
	initial begin
		axi_addr_t addr;
		axi_addr_t base;
		axi_data_t data;
		rng           = 32'hd4ae_e6cb;
		tests_run     = 0;
		errors_before = 0;
		rst_n         = 1'b0;
		select        = 1'b0;
		write_enable  = 1'b0;
		byte_enable   = '0;
		address       = '0;
		write_data    = '0;
		cache_req     = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		rst_n = 1'b1;

		// quiet after reset, then every word reads as zero
		go_idle(5);
		for (int i = 0; i < ZERO_READS; i++) begin
			random_addr(addr);
			core_read(addr);
		end
		go_idle(1);
		finish_test("reset_and_zero_read");

		// partial writes merge into the old word
		for (int i = 0; i < STRB_PAIRS; i++) begin
			random_addr(addr);
			random_word(data);
			rng = xorshift32(rng);
			core_write(addr, data, axi_strb_t'(rng));
			core_read(addr);
		end
		go_idle(1);
		finish_test("byte_strobe_write");

		// fill a whole line with known data, then fetch it from a random word
		for (int i = 0; i < FILL_LINES; i++) begin
			random_addr(addr);
			base = addr & ~axi_addr_t'(LINE_WORDS * 4 - 1);
			for (int k = 0; k < LINE_WORDS; k++) begin
				random_word(data);
				core_write(base + axi_addr_t'(k * 4), data, '1);
			end
			line_fill(addr);
		end
		go_idle(1);
		finish_test("cache_line_wrap");

		for (int i = 0; i < WB_PAIRS; i++) begin
			random_addr(addr);
			random_word(data);
			write_back(addr, data);
			core_read(addr);
		end
		go_idle(1);
		finish_test("cache_write_back");

		// mixed traffic over all banks
		for (int i = 0; i < MIX_OPS; i++) begin
			random_addr(addr);
			random_word(data);
			rng = xorshift32(rng);
			case (rng % 4)
				0: core_read(addr);
				1: core_write(addr, data, axi_strb_t'(rng >> 8));
				2: line_fill(addr);
				default: write_back(addr, data);
			endcase
		end
		go_idle(1);
		finish_test("random_mix");

		// read back everything so a stray write into another bank shows up
		for (int w = 0; w < MEM_WORDS; w++) begin
			core_read(axi_addr_t'(w * 4));
		end
		go_idle(2);
		finish_test("bank_isolation_sweep");

		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule
